// ==== src/mldsa_dcmp_pkg.sv ====
`default_nettype none

package mldsa_dcmp_pkg;

    // ML-DSA modulus
    localparam int unsigned MLDSA_Q = 8380417;
    // (q-1)/32 for this parameter set
    localparam int unsigned MLDSA_GAMMA2 = 261888;
    localparam int unsigned DCMP_TWO_GAMMA2 = 523776;

    // One coefficient slot in a memory word, top bit unused
    localparam int unsigned DCMP_REG_SIZE = 24;
    localparam int unsigned DCMP_COEF_PER_WORD = 4;
    // 256 coefficients, four per word
    localparam int unsigned DCMP_NUM_WORDS = 64;
    localparam int unsigned DCMP_ADDR_WIDTH = 10;
    // Word index within one polynomial
    localparam int unsigned DCMP_IDX_WIDTH = $clog2(DCMP_NUM_WORDS);

    // Operation selected at start
    typedef enum logic {
        DCMP_SIGN   = 1'b0,
        DCMP_VERIFY = 1'b1
    } dcmp_mode_t;

    // Memory command
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_t;

    typedef logic [DCMP_ADDR_WIDTH-1:0] mem_addr_t;

    // Request to main, hint or flag memory
    typedef struct packed {
        rw_cmd_t   cmd;
        mem_addr_t addr;
    } mem_req_t;

    // Registered result of one lane
    typedef struct packed {
        // Low bits, already mapped into [0, q)
        logic [DCMP_REG_SIZE-2:0] r0;
        // High bits after the optional usehint step
        logic [3:0]               r1;
        // Plain r1 is nonzero
        logic                     z_nez;
    } lane_res_t;

endpackage

`default_nettype wire

// ==== src/dcmp_ctrl.sv ====
`default_nettype none

module dcmp_ctrl (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         zeroize_i,
    input  wire                         start_i,
    input  mldsa_dcmp_pkg::dcmp_mode_t  mode_i,
    input  mldsa_dcmp_pkg::mem_addr_t   src_base_i,
    input  mldsa_dcmp_pkg::mem_addr_t   dest_base_i,
    input  mldsa_dcmp_pkg::mem_addr_t   hint_base_i,
    output mldsa_dcmp_pkg::mem_req_t    rd_req_o,
    output mldsa_dcmp_pkg::mem_req_t    hint_rd_req_o,
    output mldsa_dcmp_pkg::mem_req_t    wr_req_o,
    output mldsa_dcmp_pkg::mem_req_t    z_wr_req_o,
    output logic                        lane_en_o,
    output logic                        done_o
);

    // Read phase state
    logic                                       rd_active;
    logic [mldsa_dcmp_pkg::DCMP_IDX_WIDTH-1:0] cnt;
    logic                                       verify_q;
    // Valid and index follow each word through data return and the lane register
    logic                                       vld_d1;
    logic                                       vld_d2;
    logic [mldsa_dcmp_pkg::DCMP_IDX_WIDTH-1:0] idx_d1;
    logic [mldsa_dcmp_pkg::DCMP_IDX_WIDTH-1:0] idx_d2;
    logic                                       done_q;
    logic                                       start_ok;

    // New run only once the previous one has drained
    assign start_ok = start_i && !rd_active && !vld_d1 && !vld_d2;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_active <= 1'b0;
            cnt       <= '0;
            verify_q  <= 1'b0;
            vld_d1    <= 1'b0;
            vld_d2    <= 1'b0;
            idx_d1    <= '0;
            idx_d2    <= '0;
            done_q    <= 1'b0;
        end else if (zeroize_i) begin
            rd_active <= 1'b0;
            cnt       <= '0;
            verify_q  <= 1'b0;
            vld_d1    <= 1'b0;
            vld_d2    <= 1'b0;
            idx_d1    <= '0;
            idx_d2    <= '0;
            done_q    <= 1'b0;
        end else begin
            if (start_ok) begin
                rd_active <= 1'b1;
                cnt       <= '0;
                // Mode is held for the whole run
                verify_q  <= (mode_i == mldsa_dcmp_pkg::DCMP_VERIFY);
            end else if (rd_active) begin
                // Stop after the last word is requested
                if (cnt == mldsa_dcmp_pkg::DCMP_NUM_WORDS - 1) begin
                    rd_active <= 1'b0;
                end
                cnt <= cnt + 1'b1;
            end
            vld_d1 <= rd_active;
            idx_d1 <= cnt;
            vld_d2 <= vld_d1;
            idx_d2 <= idx_d1;
            // Last result is leaving the lanes
            done_q <= vld_d2 && (idx_d2 == mldsa_dcmp_pkg::DCMP_NUM_WORDS - 1);
        end
    end

    always_comb begin
        rd_req_o.cmd  = rd_active ? mldsa_dcmp_pkg::RW_READ : mldsa_dcmp_pkg::RW_IDLE;
        rd_req_o.addr = src_base_i + mldsa_dcmp_pkg::mem_addr_t'(cnt);

        // Hints only needed for verify
        hint_rd_req_o.cmd  = (rd_active && verify_q) ? mldsa_dcmp_pkg::RW_READ
                                                     : mldsa_dcmp_pkg::RW_IDLE;
        hint_rd_req_o.addr = hint_base_i + mldsa_dcmp_pkg::mem_addr_t'(cnt);

        // r0 and flag written back in sign mode only
        wr_req_o.cmd  = (vld_d2 && !verify_q) ? mldsa_dcmp_pkg::RW_WRITE
                                              : mldsa_dcmp_pkg::RW_IDLE;
        wr_req_o.addr = dest_base_i + mldsa_dcmp_pkg::mem_addr_t'(idx_d2);
        z_wr_req_o.cmd  = wr_req_o.cmd;
        // Flag memory is indexed by word number
        z_wr_req_o.addr = mldsa_dcmp_pkg::mem_addr_t'(idx_d2);
    end

    // Read data is present one cycle after the request
    assign lane_en_o = vld_d1;
    assign done_o    = done_q;

endmodule

`default_nettype wire

// ==== src/dcmp_lane.sv ====
`default_nettype none

module dcmp_lane (
    input  wire                                        clk,
    input  wire                                        reset_n,
    input  wire                                        zeroize_i,
    input  wire                                        en_i,
    input  wire                                        verify_i,
    input  wire [mldsa_dcmp_pkg::DCMP_REG_SIZE-2:0]    coef_i,
    input  wire                                        hint_i,
    output mldsa_dcmp_pkg::lane_res_t                  res_o,
    output logic                                       res_valid_o
);

    // High bits before the corner fix
    logic [3:0]                                 r1_raw;
    // Coefficient lies above q-1-GAMMA2
    logic                                       corner;
    logic [3:0]                                 r1;
    // Centered r0 in two's complement, one bit wider than a coefficient
    logic [mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  r0_c;
    logic                                       r0_neg;
    logic                                       r0_pos;
    logic [mldsa_dcmp_pkg::DCMP_REG_SIZE-2:0]  r0_q;
    logic [3:0]                                 r1_hint;
    mldsa_dcmp_pkg::lane_res_t                  res_d;
    mldsa_dcmp_pkg::lane_res_t                  res_q;
    logic                                       valid_q;

    // r1 counts the odd multiples of GAMMA2 that r exceeds
    always_comb begin
        r1_raw = '0;
        for (int k = 0; k < 15; k++) begin
            if (coef_i > (2 * k + 1) * mldsa_dcmp_pkg::MLDSA_GAMMA2) begin
                r1_raw = 4'(k + 1);
            end
        end
    end

    // Sixteenth multiple would give r - r0 = q-1
    assign corner = (coef_i > mldsa_dcmp_pkg::MLDSA_Q - 1 - mldsa_dcmp_pkg::MLDSA_GAMMA2);

    always_comb begin
        if (corner) begin
            // r1 forced to 0, r0 = r - q which is r0 - 1
            r1   = '0;
            r0_c = {1'b0, coef_i} - 24'(mldsa_dcmp_pkg::MLDSA_Q);
        end else begin
            r1   = r1_raw;
            r0_c = {1'b0, coef_i} - 24'(r1_raw * mldsa_dcmp_pkg::DCMP_TWO_GAMMA2);
        end
    end

    assign r0_neg = r0_c[mldsa_dcmp_pkg::DCMP_REG_SIZE-1];
    // Strictly positive r0, at most GAMMA2 by construction
    assign r0_pos = !r0_neg && (r0_c != '0);

    // Negative r0 stored as r0 + q
    assign r0_q = r0_neg ? 23'(r0_c + 24'(mldsa_dcmp_pkg::MLDSA_Q))
                         : r0_c[mldsa_dcmp_pkg::DCMP_REG_SIZE-2:0];

    // Usehint, wraps mod 16 through the 4-bit width
    assign r1_hint = r0_pos ? r1 + 4'd1 : r1 - 4'd1;

    always_comb begin
        res_d.r0    = r0_q;
        res_d.r1    = (verify_i && hint_i) ? r1_hint : r1;
        // Flag taken from r1 before usehint
        res_d.z_nez = (r1 != '0);
    end

    // Result payload, wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            res_q <= '0;
        end else if (en_i) begin
            res_q <= res_d;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (zeroize_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= en_i;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== src/dcmp_w1_pack.sv ====
`default_nettype none

module dcmp_w1_pack (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         zeroize_i,
    input  wire [15:0]  r1_i,
    input  wire         valid_i,
    output logic [63:0] w1_o,
    output logic        w1_valid_o
);

    // Position of the next group within the word
    logic [1:0]  phase;
    // First three groups, oldest in the low bits
    logic [47:0] acc;
    logic [63:0] w1_q;
    logic        w1_valid_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase      <= '0;
            w1_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            phase      <= '0;
            w1_valid_q <= 1'b0;
        end else begin
            // Pulse after the fourth group
            w1_valid_q <= valid_i && (phase == 2'd3);
            if (valid_i) begin
                phase <= phase + 2'd1;
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            acc  <= '0;
            w1_q <= '0;
        end else if (valid_i) begin
            // Newest group enters at the top and moves down
            acc <= {r1_i, acc[47:16]};
            if (phase == 2'd3) begin
                w1_q <= {r1_i, acc};
            end
        end
    end

    assign w1_o       = w1_q;
    assign w1_valid_o = w1_valid_q;

endmodule

`default_nettype wire

// ==== src/dcmp_top.sv ====
`default_nettype none

module dcmp_top (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize_i,
    input  wire                                   start_i,
    input  mldsa_dcmp_pkg::dcmp_mode_t            mode_i,
    input  mldsa_dcmp_pkg::mem_addr_t             src_base_i,
    input  mldsa_dcmp_pkg::mem_addr_t             dest_base_i,
    input  mldsa_dcmp_pkg::mem_addr_t             hint_base_i,
    output mldsa_dcmp_pkg::mem_req_t              mem_rd_req_o,
    input  wire [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0] mem_rd_data_i,
    output mldsa_dcmp_pkg::mem_req_t              mem_hint_rd_req_o,
    input  wire [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0] mem_hint_rd_data_i,
    output mldsa_dcmp_pkg::mem_req_t              mem_wr_req_o,
    output logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0] mem_wr_data_o,
    output mldsa_dcmp_pkg::mem_req_t              z_wr_req_o,
    output logic [3:0]                            z_nez_o,
    output logic [63:0]                           w1_o,
    output logic                                  w1_valid_o,
    output logic                                  done_o
);

    logic                                                  lane_en;
    // Hint data arrives alongside the coefficients in this cycle
    logic                                                  hint_vld_q;
    mldsa_dcmp_pkg::lane_res_t [mldsa_dcmp_pkg::DCMP_COEF_PER_WORD-1:0] lane_res;
    logic [mldsa_dcmp_pkg::DCMP_COEF_PER_WORD-1:0]        lane_vld;
    // Four r1 nibbles of one word, lane 0 lowest
    logic [15:0]                                           r1_word;

    dcmp_ctrl i_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .start_i       (start_i),
        .mode_i        (mode_i),
        .src_base_i    (src_base_i),
        .dest_base_i   (dest_base_i),
        .hint_base_i   (hint_base_i),
        .rd_req_o      (mem_rd_req_o),
        .hint_rd_req_o (mem_hint_rd_req_o),
        .wr_req_o      (mem_wr_req_o),
        .z_wr_req_o    (z_wr_req_o),
        .lane_en_o     (lane_en),
        .done_o        (done_o)
    );

    // Usehint applies only to words whose hint read was issued
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_vld_q <= 1'b0;
        end else if (zeroize_i) begin
            hint_vld_q <= 1'b0;
        end else begin
            hint_vld_q <= (mem_hint_rd_req_o.cmd == mldsa_dcmp_pkg::RW_READ);
        end
    end

    for (genvar i = 0; i < mldsa_dcmp_pkg::DCMP_COEF_PER_WORD; i++) begin : gen_lane
        dcmp_lane i_lane (
            .clk         (clk),
            .reset_n     (reset_n),
            .zeroize_i   (zeroize_i),
            .en_i        (lane_en),
            .verify_i    (hint_vld_q),
            // Low 23 bits of the slot hold the coefficient
            .coef_i      (mem_rd_data_i[i*mldsa_dcmp_pkg::DCMP_REG_SIZE +:
                                        mldsa_dcmp_pkg::DCMP_REG_SIZE-1]),
            // Hint is the slot LSB
            .hint_i      (mem_hint_rd_data_i[i*mldsa_dcmp_pkg::DCMP_REG_SIZE]),
            .res_o       (lane_res[i]),
            .res_valid_o (lane_vld[i])
        );

        // r0 zero-extended into its slot
        assign mem_wr_data_o[i*mldsa_dcmp_pkg::DCMP_REG_SIZE +: mldsa_dcmp_pkg::DCMP_REG_SIZE] =
            {1'b0, lane_res[i].r0};
        assign z_nez_o[i]         = lane_res[i].z_nez;
        assign r1_word[i*4 +: 4]  = lane_res[i].r1;
    end

    // Lanes run in lockstep, lane 0 valid stands for all
    dcmp_w1_pack i_pack (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .r1_i       (r1_word),
        .valid_i    (lane_vld[0]),
        .w1_o       (w1_o),
        .w1_valid_o (w1_valid_o)
    );

endmodule

`default_nettype wire

// ==== dv/dcmp_sva.sv ====
`default_nettype none

module dcmp_sva (
    input wire                      clk,
    input wire                      reset_n,
    input wire                      zeroize_i,
    input mldsa_dcmp_pkg::rw_cmd_t  rd_cmd_i,
    input mldsa_dcmp_pkg::rw_cmd_t  hint_cmd_i,
    input mldsa_dcmp_pkg::rw_cmd_t  wr_cmd_i,
    input mldsa_dcmp_pkg::rw_cmd_t  z_cmd_i,
    input wire                      w1_valid_i,
    input wire                      done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // A word whose hint was read is never written back
    a_no_wr_verify: assert property (@(posedge clk) disable iff (!reset_n)
        (hint_cmd_i == mldsa_dcmp_pkg::RW_READ) |->
            ##2 (wr_cmd_i != mldsa_dcmp_pkg::RW_WRITE)
                && (z_cmd_i != mldsa_dcmp_pkg::RW_WRITE))
        else begin
            $error("write request issued in verify mode");
            fail_cnt++;
        end

    // Fourth word of a group was read three cycles before each w1 pulse
    a_w1_timing: assert property (@(posedge clk) disable iff (!reset_n)
        w1_valid_i |-> ($past(rd_cmd_i, 3) == mldsa_dcmp_pkg::RW_READ) ##1 !w1_valid_i)
        else begin
            $error("w1_valid_o out of step with the reads or high on two consecutive cycles");
            fail_cnt++;
        end

    // done_o comes with the last w1 word and lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> w1_valid_i ##1 !done_i)
        else begin
            $error("done_o without the last w1 word or longer than one cycle");
            fail_cnt++;
        end

    // Zeroize empties the pipeline at once
    a_zeroize_idle: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (rd_cmd_i == mldsa_dcmp_pkg::RW_IDLE)
                   && (hint_cmd_i == mldsa_dcmp_pkg::RW_IDLE)
                   && (wr_cmd_i == mldsa_dcmp_pkg::RW_IDLE)
                   && (z_cmd_i == mldsa_dcmp_pkg::RW_IDLE))
        else begin
            $error("memory request active in the cycle after zeroize");
            fail_cnt++;
        end

endmodule

bind dcmp_top dcmp_sva i_sva (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize_i  (zeroize_i),
    .rd_cmd_i   (mem_rd_req_o.cmd),
    .hint_cmd_i (mem_hint_rd_req_o.cmd),
    .wr_cmd_i   (mem_wr_req_o.cmd),
    .z_cmd_i    (z_wr_req_o.cmd),
    .w1_valid_i (w1_valid_o),
    .done_i     (done_o)
);

`default_nettype wire

// ==== dv/dcmp_tb.sv ====
`default_nettype none

module dcmp_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                        clk;
    logic                                        reset_n;
    logic                                        zeroize;
    logic                                        start;
    mldsa_dcmp_pkg::dcmp_mode_t                  mode;
    mldsa_dcmp_pkg::mem_addr_t                   src_base;
    mldsa_dcmp_pkg::mem_addr_t                   dest_base;
    mldsa_dcmp_pkg::mem_addr_t                   hint_base;
    mldsa_dcmp_pkg::mem_req_t                    rd_req;
    mldsa_dcmp_pkg::mem_req_t                    hint_req;
    mldsa_dcmp_pkg::mem_req_t                    wr_req;
    mldsa_dcmp_pkg::mem_req_t                    z_req;
    logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  rd_data = '0;
    logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  hint_data = '0;
    logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  wr_data;
    logic [3:0]                                  z_nez;
    logic [63:0]                                 w1;
    logic                                        w1_valid;
    logic                                        done;

    // Coefficient and hint memories
    logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  coef_mem [1024];
    logic [4*mldsa_dcmp_pkg::DCMP_REG_SIZE-1:0]  hint_mem [1024];
    // Expected results of the current run
    mldsa_dcmp_pkg::lane_res_t                   exp_res [256];
    logic [63:0]                                 exp_w1 [16];
    mldsa_dcmp_pkg::dcmp_mode_t                  run_mode;

    int rd_cnt;
    int hint_cnt;
    int wr_cnt;
    int w1_cnt;
    int done_cnt;
    int err_cnt;
    int check_cnt;
    int test_cnt;
    int test_err_base;
    // Any activity is an error while set
    bit quiet;

    dcmp_top i_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize_i          (zeroize),
        .start_i            (start),
        .mode_i             (mode),
        .src_base_i         (src_base),
        .dest_base_i        (dest_base),
        .hint_base_i        (hint_base),
        .mem_rd_req_o       (rd_req),
        .mem_rd_data_i      (rd_data),
        .mem_hint_rd_req_o  (hint_req),
        .mem_hint_rd_data_i (hint_data),
        .mem_wr_req_o       (wr_req),
        .mem_wr_data_o      (wr_data),
        .z_wr_req_o         (z_req),
        .z_nez_o            (z_nez),
        .w1_o               (w1),
        .w1_valid_o         (w1_valid),
        .done_o             (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Decompose from the definition with centered remainder then corner fix
    function automatic mldsa_dcmp_pkg::lane_res_t decompose_ref(
        int coef, mldsa_dcmp_pkg::dcmp_mode_t md, logic hint);
        mldsa_dcmp_pkg::lane_res_t res;
        int q;
        int tg;
        int r0;
        int r1;
        q  = int'(mldsa_dcmp_pkg::MLDSA_Q);
        tg = int'(mldsa_dcmp_pkg::DCMP_TWO_GAMMA2);
        r0 = coef % tg;
        if (r0 > int'(mldsa_dcmp_pkg::MLDSA_GAMMA2)) begin
            r0 = r0 - tg;
        end
        if (coef - r0 == q - 1) begin
            r1 = 0;
            r0 = r0 - 1;
        end else begin
            r1 = (coef - r0) / tg;
        end
        res.z_nez = (r1 != 0);
        // Usehint step
        if (md == mldsa_dcmp_pkg::DCMP_VERIFY && hint) begin
            r1 = (r0 > 0) ? (r1 + 1) % 16 : (r1 + 15) % 16;
        end
        res.r1 = 4'(r1);
        res.r0 = 23'((r0 < 0) ? r0 + q : r0);
        return res;
    endfunction

    // Word j holds results 16j to 16j+15 with the oldest nibble lowest
    function automatic logic [63:0] w1_ref(int j);
        logic [63:0] w;
        w = '0;
        for (int n = 0; n < 16; n++) begin
            w[n*4 +: 4] = exp_res[j*16 + n].r1;
        end
        return w;
    endfunction

    function automatic mldsa_dcmp_pkg::mem_req_t make_req(mldsa_dcmp_pkg::rw_cmd_t cmd, int addr);
        mldsa_dcmp_pkg::mem_req_t req;
        req.cmd  = cmd;
        req.addr = mldsa_dcmp_pkg::mem_addr_t'(addr);
        return req;
    endfunction

    function automatic int corner_val(int n);
        int g;
        int q;
        g = int'(mldsa_dcmp_pkg::MLDSA_GAMMA2);
        q = int'(mldsa_dcmp_pkg::MLDSA_Q);
        case (n)
            0:       return 0;
            1:       return g;
            2:       return g + 1;
            3:       return 2 * g;
            4:       return 16 * g;
            5:       return 30 * g;
            6:       return q - 1 - g;
            7:       return q - g;
            8:       return q - 2;
            default: return q - 1;
        endcase
    endfunction

    task automatic check_r0(string name, mldsa_dcmp_pkg::lane_res_t got,
                            mldsa_dcmp_pkg::lane_res_t exp);
        check_cnt++;
        if (got.r0 !== exp.r0 || got.z_nez !== exp.z_nez) begin
            $display("[FAIL] %0t %s got r0=%h z_nez=%b exp r0=%h z_nez=%b",
                     $time, name, got.r0, got.z_nez, exp.r0, exp.z_nez);
            err_cnt++;
        end
    endtask

    task automatic check_w1(string name, logic [63:0] got, logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // Address only matters for an active command
    task automatic check_req(string name, mldsa_dcmp_pkg::mem_req_t got,
                             mldsa_dcmp_pkg::mem_req_t exp);
        check_cnt++;
        if (got.cmd !== exp.cmd
            || (exp.cmd != mldsa_dcmp_pkg::RW_IDLE && got.addr !== exp.addr)) begin
            $display("[FAIL] %0t %s got cmd=%0d addr=%h exp cmd=%0d addr=%h",
                     $time, name, got.cmd, got.addr, exp.cmd, exp.addr);
            err_cnt++;
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        check_cnt++;
        if (got != exp) begin
            $display("At %0t the run counted %0d %s where %0d were expected",
                     $time, got, what, exp);
            err_cnt++;
        end
    endtask

    task automatic fill_random(int s, int h);
        for (int k = 0; k < 64; k++) begin
            for (int l = 0; l < 4; l++) begin
                coef_mem[s+k][l*24 +: 24] = 24'($urandom % mldsa_dcmp_pkg::MLDSA_Q);
            end
            // Only the slot LSB is a hint and the upper bits are noise
            hint_mem[h+k] = {$urandom, $urandom, $urandom};
        end
    endtask

    task automatic fill_corner(int s, int h);
        for (int k = 0; k < 64; k++) begin
            for (int l = 0; l < 4; l++) begin
                coef_mem[s+k][l*24 +: 24] = 24'(corner_val((k*4 + l) % 10));
            end
            hint_mem[h+k] = {4{13'h0, 10'(h + k), 1'b1}};
        end
    endtask

    // Memory models with one-cycle read latency
    always @(posedge clk) begin
        if (rd_req.cmd == mldsa_dcmp_pkg::RW_READ) begin
            rd_data <= coef_mem[rd_req.addr];
        end
        if (hint_req.cmd == mldsa_dcmp_pkg::RW_READ) begin
            hint_data <= hint_mem[hint_req.addr];
        end
    end

    // Compares every request, write and w1 word as it happens
    always @(posedge clk) begin
        mldsa_dcmp_pkg::lane_res_t got;
        if (reset_n) begin
            if (quiet && (rd_req.cmd != mldsa_dcmp_pkg::RW_IDLE
                          || hint_req.cmd != mldsa_dcmp_pkg::RW_IDLE
                          || wr_req.cmd != mldsa_dcmp_pkg::RW_IDLE
                          || z_req.cmd != mldsa_dcmp_pkg::RW_IDLE
                          || w1_valid || done)) begin
                $display("At %0t the DUT was still active after zeroize", $time);
                err_cnt++;
            end
            if (rd_req.cmd != mldsa_dcmp_pkg::RW_IDLE) begin
                check_req("mem_rd_req_o", rd_req,
                          make_req(mldsa_dcmp_pkg::RW_READ, int'(src_base) + rd_cnt));
                rd_cnt++;
            end
            if (hint_req.cmd != mldsa_dcmp_pkg::RW_IDLE) begin
                check_req("mem_hint_rd_req_o", hint_req,
                          make_req(run_mode == mldsa_dcmp_pkg::DCMP_VERIFY ?
                                   mldsa_dcmp_pkg::RW_READ : mldsa_dcmp_pkg::RW_IDLE,
                                   int'(hint_base) + hint_cnt));
                hint_cnt++;
            end
            if (wr_req.cmd != mldsa_dcmp_pkg::RW_IDLE
                || z_req.cmd != mldsa_dcmp_pkg::RW_IDLE) begin
                if (wr_cnt < 64) begin
                    check_req("mem_wr_req_o", wr_req,
                              make_req(run_mode == mldsa_dcmp_pkg::DCMP_SIGN ?
                                       mldsa_dcmp_pkg::RW_WRITE : mldsa_dcmp_pkg::RW_IDLE,
                                       int'(dest_base) + wr_cnt));
                    check_req("z_wr_req_o", z_req,
                              make_req(run_mode == mldsa_dcmp_pkg::DCMP_SIGN ?
                                       mldsa_dcmp_pkg::RW_WRITE : mldsa_dcmp_pkg::RW_IDLE,
                                       wr_cnt));
                    for (int l = 0; l < 4; l++) begin
                        got.r0    = wr_data[l*24 +: 23];
                        got.r1    = exp_res[wr_cnt*4 + l].r1;
                        got.z_nez = z_nez[l];
                        check_r0($sformatf("mem_wr_data_o[%0d] lane %0d", wr_cnt, l), got,
                                 exp_res[wr_cnt*4 + l]);
                    end
                end
                wr_cnt++;
            end
            if (w1_valid) begin
                if (w1_cnt < 16) begin
                    check_w1($sformatf("w1_o[%0d]", w1_cnt), w1, exp_w1[w1_cnt]);
                end
                w1_cnt++;
            end
            if (done) begin
                done_cnt++;
                check_count("w1 words before done_o", w1_cnt, 16);
            end
        end
    end

    // Set bases and mode, derive expected results, then pulse start
    task automatic launch_run(mldsa_dcmp_pkg::dcmp_mode_t md, int s, int d, int h);
        @(posedge clk);
        #1;
        mode      = md;
        run_mode  = md;
        src_base  = mldsa_dcmp_pkg::mem_addr_t'(s);
        dest_base = mldsa_dcmp_pkg::mem_addr_t'(d);
        hint_base = mldsa_dcmp_pkg::mem_addr_t'(h);
        for (int k = 0; k < 64; k++) begin
            for (int l = 0; l < 4; l++) begin
                exp_res[k*4 + l] = decompose_ref(int'(coef_mem[s+k][l*24 +: 23]), md,
                                                 hint_mem[h+k][l*24]);
            end
        end
        for (int j = 0; j < 16; j++) begin
            exp_w1[j] = w1_ref(j);
        end
        rd_cnt        = 0;
        hint_cnt      = 0;
        wr_cnt        = 0;
        w1_cnt        = 0;
        done_cnt      = 0;
        test_err_base = err_cnt;
        start         = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic report_test(string name);
        test_cnt++;
        $display("test %-14s %s (%0d errors)", name,
                 (err_cnt == test_err_base) ? "ok" : "failed", err_cnt - test_err_base);
    endtask

    task automatic finish_run(string name);
        int t;
        t = 0;
        while (done_cnt == 0) begin
            if (t >= 500) begin
                $display("Timed out waiting for done_o in test %s", name);
                $display("FAIL: see errors above");
                $finish;
            end
            @(posedge clk);
            #1;
            t++;
        end
        // Let a second done pulse show up if there is one
        repeat (3) @(posedge clk);
        #1;
        check_count("read requests", rd_cnt, 64);
        check_count("hint reads", hint_cnt,
                    (run_mode == mldsa_dcmp_pkg::DCMP_VERIFY) ? 64 : 0);
        check_count("write requests", wr_cnt,
                    (run_mode == mldsa_dcmp_pkg::DCMP_SIGN) ? 64 : 0);
        check_count("w1 words", w1_cnt, 16);
        check_count("done pulses", done_cnt, 1);
        report_test(name);
    endtask

    initial begin
        void'($urandom(32'h3edfa337));
        reset_n   = 1'b0;
        zeroize   = 1'b0;
        start     = 1'b0;
        mode      = mldsa_dcmp_pkg::DCMP_SIGN;
        run_mode  = mldsa_dcmp_pkg::DCMP_SIGN;
        src_base  = '0;
        dest_base = '0;
        hint_base = '0;
        quiet     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        // Idle outputs while in reset
        test_err_base = err_cnt;
        check_req("mem_rd_req_o", rd_req, make_req(mldsa_dcmp_pkg::RW_IDLE, 0));
        check_req("mem_wr_req_o", wr_req, make_req(mldsa_dcmp_pkg::RW_IDLE, 0));
        check_req("mem_hint_rd_req_o", hint_req, make_req(mldsa_dcmp_pkg::RW_IDLE, 0));
        check_count("w1_valid_o pulses in reset", int'(w1_valid), 0);
        check_count("done_o pulses in reset", int'(done), 0);
        reset_n = 1'b1;
        report_test("reset");

        fill_random('h040, 'h200);
        launch_run(mldsa_dcmp_pkg::DCMP_SIGN, 'h040, 'h100, 'h200);
        finish_run("sign_random");
        fill_corner('h080, 'h280);
        launch_run(mldsa_dcmp_pkg::DCMP_SIGN, 'h080, 'h180, 'h280);
        finish_run("sign_corner");
        fill_random('h0c0, 'h300);
        launch_run(mldsa_dcmp_pkg::DCMP_VERIFY, 'h0c0, 'h1c0, 'h300);
        finish_run("verify_random");
        fill_corner('h140, 'h340);
        launch_run(mldsa_dcmp_pkg::DCMP_VERIFY, 'h140, 'h240, 'h340);
        finish_run("verify_corner");

        // Abort a run partway through
        fill_random('h000, 'h380);
        launch_run(mldsa_dcmp_pkg::DCMP_SIGN, 'h000, 'h300, 'h380);
        repeat (19) @(posedge clk);
        #1;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        quiet   = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        quiet = 1'b0;
        report_test("zeroize");
        launch_run(mldsa_dcmp_pkg::DCMP_VERIFY, 'h000, 'h300, 'h380);
        finish_run("after_zeroize");

        // Bound assertion failures count as errors too
        err_cnt += int'(i_dut.i_sva.fail_cnt);
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mldsa_dcmp.f ====
src/mldsa_dcmp_pkg.sv
src/dcmp_ctrl.sv
src/dcmp_lane.sv
src/dcmp_w1_pack.sv
src/dcmp_top.sv
dv/dcmp_sva.sv
dv/dcmp_tb.sv

// ==== Bender.yml ====
package:
  name: mldsa_dcmp

dependencies: {}

sources:
  - src/mldsa_dcmp_pkg.sv
  - src/dcmp_ctrl.sv
  - src/dcmp_lane.sv
  - src/dcmp_w1_pack.sv
  - src/dcmp_top.sv
  - target: test
    files:
      - dv/dcmp_sva.sv
      - dv/dcmp_tb.sv
